// File: ipv4_rw_pkg.sv
// Header word is network order, byte 0 in bits [159:152]. IHL is taken as 5.
// Register offsets are byte addresses on an 8-bit APB address.
package ipv4_rw_pkg;

    ////////////////////////////////////////////////////////////
    // Header layout.
    ////////////////////////////////////////////////////////////
    localparam int HDR_BITS   = 160;
    localparam int FIELD_W    = 16;            // Checksum arithmetic width.
    localparam int ADDR_W     = 32;

    localparam int TTL_LSB    = 80;            // TTL in the upper byte, protocol below.
    localparam int CSUM_LSB   = 64;
    localparam int SRC_HI_LSB = 48;
    localparam int SRC_LO_LSB = 32;

    localparam int CSUM_LATENCY = 2;           // Engine cycles, request to result.

    ////////////////////////////////////////////////////////////
    // Register map.
    ////////////////////////////////////////////////////////////
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_NAT_ADDR = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_PKT_CNT  = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_DROP_CNT = 8'h0C;

    localparam int CTRL_TTL_DEC_BIT = 0;
    localparam int CTRL_NAT_EN_BIT  = 1;

    ////////////////////////////////////////////////////////////
    // Sequencer types.
    ////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        IDLE,
        TTL_UPD,
        SRC_HI_UPD,
        SRC_LO_UPD,
        WAIT_RES,
        OUT
    } rw_state_e;

    // Field whose checksum update is in flight.
    typedef enum logic [1:0] {
        TTL,
        SRC_HI,
        SRC_LO
    } rw_field_e;

endpackage

// File: csum_if.sv
// One incremental checksum request and its result. No back-pressure,
// the engine takes a request on every cycle that req_valid is high.
`timescale 1ns/1ps

interface csum_if;

    logic        req_valid;
    logic [15:0] old_csum;      // Checksum before this field change.
    logic [15:0] old_field;
    logic [15:0] new_field;

    logic        res_valid;
    logic [15:0] new_csum;

    // Sequencer side.
    modport seq (
        output req_valid, old_csum, old_field, new_field,
        input  res_valid, new_csum
    );

    // Checksum engine side.
    modport eng (
        input  req_valid, old_csum, old_field, new_field,
        output res_valid, new_csum
    );

endinterface

// File: ipv4_checksum_update.sv
// RFC 1624 incremental update, HC' = ~(~HC + ~m + m'). Fixed two-cycle latency,
// one request accepted per cycle.
`timescale 1ns/1ps

module ipv4_checksum_update (
    input  logic clk,
    input  logic reset_i,
    csum_if.eng  upd
);

    // One's-complement add with end-around carry. The second add cannot carry.
    function automatic logic [15:0] add1c(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[15:0] + {15'd0, t[16]};
    endfunction

    logic        s1_valid_q;
    logic [15:0] s1_sum_q;        // ~HC + ~m.
    logic [15:0] s1_new_field_q;  // m' waits one stage.

    logic        s2_valid_q;
    logic [15:0] s2_csum_q;

    ////////////////////////////////////////////////////////////
    // Valid pipeline.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= upd.req_valid;
            s2_valid_q <= s1_valid_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data pipeline.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (upd.req_valid) begin
            s1_sum_q       <= add1c(~upd.old_csum, ~upd.old_field);
            s1_new_field_q <= upd.new_field;
        end
        if (s1_valid_q) begin
            s2_csum_q <= ~add1c(s1_sum_q, s1_new_field_q);
        end
    end

    assign upd.res_valid = s2_valid_q;
    assign upd.new_csum  = s2_csum_q;

endmodule

// File: rewrite_cfg_apb.sv
// APB slave, zero wait states. Unmapped offsets give PSLVERR and are not stored.
// Any write to a counter clears it.
`timescale 1ns/1ps

module rewrite_cfg_apb
    import ipv4_rw_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,

    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,

    output logic                  ttl_dec_en_o,
    output logic                  nat_en_o,
    output logic [ADDR_W-1:0]     nat_addr_o,

    input  logic                  fwd_pulse_i,
    input  logic                  drop_pulse_i
);

    logic                  ttl_dec_en_q;
    logic                  nat_en_q;
    logic [ADDR_W-1:0]     nat_addr_q;
    logic [APB_DATA_W-1:0] pkt_cnt_q;
    logic [APB_DATA_W-1:0] drop_cnt_q;

    logic                  access;
    logic                  wr_en;
    logic                  hit_ctrl;
    logic                  hit_nat;
    logic                  hit_pkt;
    logic                  hit_drop;
    logic                  mapped;

    assign access   = psel_i && penable_i;
    assign wr_en    = access && pwrite_i;

    assign hit_ctrl = (paddr_i == REG_CTRL);
    assign hit_nat  = (paddr_i == REG_NAT_ADDR);
    assign hit_pkt  = (paddr_i == REG_PKT_CNT);
    assign hit_drop = (paddr_i == REG_DROP_CNT);
    assign mapped   = hit_ctrl || hit_nat || hit_pkt || hit_drop;

    assign pready_o  = 1'b1;
    assign pslverr_o = access && !mapped;

    ////////////////////////////////////////////////////////////
    // Registers and counters.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ttl_dec_en_q <= 1'b0;
            nat_en_q     <= 1'b0;
            nat_addr_q   <= '0;
            pkt_cnt_q    <= '0;
            drop_cnt_q   <= '0;
        end else begin
            if (wr_en && hit_ctrl) begin
                ttl_dec_en_q <= pwdata_i[CTRL_TTL_DEC_BIT];
                nat_en_q     <= pwdata_i[CTRL_NAT_EN_BIT];
            end
            if (wr_en && hit_nat) nat_addr_q <= pwdata_i;

            if (wr_en && hit_pkt)  pkt_cnt_q <= '0;       // Clear wins over a count.
            else if (fwd_pulse_i)  pkt_cnt_q <= pkt_cnt_q + 1'b1;

            if (wr_en && hit_drop) drop_cnt_q <= '0;
            else if (drop_pulse_i) drop_cnt_q <= drop_cnt_q + 1'b1;
        end
    end

    // Read mux.
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o[CTRL_TTL_DEC_BIT] = ttl_dec_en_q;
            prdata_o[CTRL_NAT_EN_BIT]  = nat_en_q;
        end
        if (hit_nat)  prdata_o = nat_addr_q;
        if (hit_pkt)  prdata_o = pkt_cnt_q;
        if (hit_drop) prdata_o = drop_cnt_q;
    end

    assign ttl_dec_en_o = ttl_dec_en_q;
    assign nat_en_o     = nat_en_q;
    assign nat_addr_o   = nat_addr_q;

endmodule

// File: ipv4_hdr_rewrite.sv
// One header at a time. Config is sampled when the header is accepted;
// updates are chained because each needs the previous checksum.
`timescale 1ns/1ps

module ipv4_hdr_rewrite
    import ipv4_rw_pkg::*;
(
    input  logic                clk,
    input  logic                reset_i,

    input  logic                hdr_valid_i,
    input  logic [HDR_BITS-1:0] hdr_i,
    output logic                hdr_ready_o,

    output logic                out_valid_o,
    output logic [HDR_BITS-1:0] out_hdr_o,
    output logic                out_drop_o,
    input  logic                out_ready_i,

    input  logic                ttl_dec_en_i,
    input  logic                nat_en_i,
    input  logic [ADDR_W-1:0]   nat_addr_i,

    output logic                fwd_pulse_o,
    output logic                drop_pulse_o,

    csum_if.seq                 csum
);

    rw_state_e           state_q;
    rw_field_e           cur_field_q;   // Field whose result is awaited.
    logic                nat_en_q;

    logic [HDR_BITS-1:0] work_hdr_q;
    logic [ADDR_W-1:0]   nat_addr_q;
    logic                drop_q;

    logic                accept;
    logic                out_xfer;
    logic                drop_now;
    logic [FIELD_W-1:0]  ttl_word;
    logic [FIELD_W-1:0]  ttl_dec_word;
    logic [FIELD_W-1:0]  src_hi_word;
    logic [FIELD_W-1:0]  src_lo_word;
    logic                src_hi_match;
    logic                src_lo_match;

    assign hdr_ready_o = (state_q == IDLE);
    assign accept      = hdr_valid_i && hdr_ready_o;
    assign out_valid_o = (state_q == OUT);
    assign out_xfer    = out_valid_o && out_ready_i;

    assign out_hdr_o    = work_hdr_q;
    assign out_drop_o   = drop_q;
    assign fwd_pulse_o  = out_xfer && !drop_q;
    assign drop_pulse_o = out_xfer && drop_q;

    // TTL of 0 or 1 cannot be decremented and forwarded.
    assign drop_now = ttl_dec_en_i && (hdr_i[TTL_LSB+8 +: 8] <= 8'd1);

    assign ttl_word     = work_hdr_q[TTL_LSB +: FIELD_W];
    assign ttl_dec_word = {ttl_word[15:8] - 8'd1, ttl_word[7:0]};
    assign src_hi_word  = work_hdr_q[SRC_HI_LSB +: FIELD_W];
    assign src_lo_word  = work_hdr_q[SRC_LO_LSB +: FIELD_W];
    assign src_hi_match = (src_hi_word == nat_addr_q[31:16]);
    assign src_lo_match = (src_lo_word == nat_addr_q[15:0]);

    ////////////////////////////////////////////////////////////
    // Update request, driven straight from the state.
    ////////////////////////////////////////////////////////////
    always_comb begin
        csum.req_valid = 1'b0;
        csum.old_csum  = work_hdr_q[CSUM_LSB +: FIELD_W];
        csum.old_field = ttl_word;
        csum.new_field = ttl_dec_word;
        case (state_q)
            TTL_UPD: begin
                csum.req_valid = 1'b1;
            end
            SRC_HI_UPD: begin
                csum.req_valid = !src_hi_match;     // Unchanged half needs no update.
                csum.old_field = src_hi_word;
                csum.new_field = nat_addr_q[31:16];
            end
            SRC_LO_UPD: begin
                csum.req_valid = !src_lo_match;
                csum.old_field = src_lo_word;
                csum.new_field = nat_addr_q[15:0];
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // FSM.
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= IDLE;
            cur_field_q <= TTL;
            nat_en_q    <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        nat_en_q <= nat_en_i;
                        if (drop_now)          state_q <= OUT;     // Skips the engine.
                        else if (ttl_dec_en_i) state_q <= TTL_UPD;
                        else if (nat_en_i)     state_q <= SRC_HI_UPD;
                        else                   state_q <= OUT;
                    end
                end
                TTL_UPD: begin
                    cur_field_q <= TTL;
                    state_q     <= WAIT_RES;
                end
                SRC_HI_UPD: begin
                    cur_field_q <= SRC_HI;
                    state_q     <= src_hi_match ? SRC_LO_UPD : WAIT_RES;
                end
                SRC_LO_UPD: begin
                    cur_field_q <= SRC_LO;
                    state_q     <= src_lo_match ? OUT : WAIT_RES;
                end
                WAIT_RES: begin
                    if (csum.res_valid) begin
                        case (cur_field_q)
                            TTL:     state_q <= nat_en_q ? SRC_HI_UPD : OUT;
                            SRC_HI:  state_q <= SRC_LO_UPD;
                            default: state_q <= OUT;
                        endcase
                    end
                end
                OUT: begin
                    if (out_ready_i) state_q <= IDLE;   // Held under back-pressure.
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Working header. Fields are written with the request, checksum with the result.
    always_ff @(posedge clk) begin
        case (state_q)
            IDLE: begin
                if (accept) begin
                    work_hdr_q <= hdr_i;
                    nat_addr_q <= nat_addr_i;
                    drop_q     <= drop_now;
                end
            end
            TTL_UPD:    work_hdr_q[TTL_LSB +: FIELD_W]    <= ttl_dec_word;
            SRC_HI_UPD: work_hdr_q[SRC_HI_LSB +: FIELD_W] <= nat_addr_q[31:16];
            SRC_LO_UPD: work_hdr_q[SRC_LO_LSB +: FIELD_W] <= nat_addr_q[15:0];
            WAIT_RES: begin
                if (csum.res_valid) work_hdr_q[CSUM_LSB +: FIELD_W] <= csum.new_csum;
            end
            default: ;
        endcase
    end

endmodule

// File: ipv4_rw_top.sv
// IPv4 header rewrite stage. IHL 5 only, no input checksum check, no L4 fix-up.
`timescale 1ns/1ps

module ipv4_rw_top
    import ipv4_rw_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_i,

    // APB configuration port.
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [APB_ADDR_W-1:0] paddr_i,
    input  logic [APB_DATA_W-1:0] pwdata_i,
    output logic [APB_DATA_W-1:0] prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,

    // Header in.
    input  logic                  hdr_valid_i,
    input  logic [HDR_BITS-1:0]   hdr_i,
    output logic                  hdr_ready_o,

    // Header out.
    output logic                  out_valid_o,
    output logic [HDR_BITS-1:0]   out_hdr_o,
    output logic                  out_drop_o,
    input  logic                  out_ready_i
);

    logic              ttl_dec_en;
    logic              nat_en;
    logic [ADDR_W-1:0] nat_addr;
    logic              fwd_pulse;
    logic              drop_pulse;

    csum_if csum_link ();

    ////////////////////////////////////////////////////////////
    // Blocks.
    ////////////////////////////////////////////////////////////
    rewrite_cfg_apb rewrite_cfg_apb_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .ttl_dec_en_o (ttl_dec_en),
        .nat_en_o     (nat_en),
        .nat_addr_o   (nat_addr),
        .fwd_pulse_i  (fwd_pulse),
        .drop_pulse_i (drop_pulse)
    );

    ipv4_hdr_rewrite ipv4_hdr_rewrite_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .hdr_valid_i  (hdr_valid_i),
        .hdr_i        (hdr_i),
        .hdr_ready_o  (hdr_ready_o),
        .out_valid_o  (out_valid_o),
        .out_hdr_o    (out_hdr_o),
        .out_drop_o   (out_drop_o),
        .out_ready_i  (out_ready_i),
        .ttl_dec_en_i (ttl_dec_en),
        .nat_en_i     (nat_en),
        .nat_addr_i   (nat_addr),
        .fwd_pulse_o  (fwd_pulse),
        .drop_pulse_o (drop_pulse),
        .csum         (csum_link.seq)
    );

    ipv4_checksum_update ipv4_checksum_update_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .upd     (csum_link.eng)
    );

endmodule

// File: ipv4_rw_assert.sv
// Bound into ipv4_hdr_rewrite. Checks output hold under back-pressure, engine
// latency, and header acceptance only while the sequencer is free.
`timescale 1ns/1ps

module ipv4_rw_assert
    import ipv4_rw_pkg::*;
(
    input logic                clk,
    input logic                reset_i,
    input logic                hdr_ready_i,
    input logic                out_valid_i,
    input logic                out_ready_i,
    input logic [HDR_BITS-1:0] out_hdr_i,
    input logic                out_drop_i,
    input logic                req_valid_i,
    input logic                res_valid_i
);

    int unsigned fail_cnt = 0;

    // Output held stable while the sink stalls.
    a_out_hold: assert property (@(posedge clk) disable iff (reset_i)
        (out_valid_i && !out_ready_i) |=>
            (out_valid_i && $stable(out_hdr_i) && $stable(out_drop_i)))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("Output header or drop flag changed under back-pressure");
        end

    ////////////////////////////////////////////////////////////
    // Engine latency, both directions.
    ////////////////////////////////////////////////////////////
    a_res_after_req: assert property (@(posedge clk) disable iff (reset_i)
        req_valid_i |-> ##CSUM_LATENCY res_valid_i)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("Checksum result missing %0d cycles after request", CSUM_LATENCY);
        end

    a_req_before_res: assert property (@(posedge clk) disable iff (reset_i)
        res_valid_i |-> $past(req_valid_i, CSUM_LATENCY))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("Checksum result without a matching request");
        end

    // Ready only with no output pending and nothing in the engine.
    a_ready_idle: assert property (@(posedge clk) disable iff (reset_i)
        hdr_ready_i |-> (!out_valid_i && !req_valid_i && !res_valid_i))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("hdr_ready_o high while a header is still in the sequencer");
        end

endmodule

bind ipv4_hdr_rewrite ipv4_rw_assert ipv4_rw_assert_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .hdr_ready_i (hdr_ready_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_hdr_i   (out_hdr_o),
    .out_drop_i  (out_drop_o),
    .req_valid_i (csum.req_valid),
    .res_valid_i (csum.res_valid)
);

// File: tb_clkgen.sv
// Testbench clock and reset. 100 ns period, reset held high for 16 cycles
// and released on a falling edge.
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;                     // Released away from the active edge.
    end

endmodule

// File: tb_top.sv
// Testbench for the IPv4 header rewrite stage. Random stimulus from $urandom, seed 32'h897c.
// Expected checksums are recomputed over the whole header, never updated incrementally.
`timescale 1ns/1ps

module tb_top
    import ipv4_rw_pkg::*;
();

    localparam int N_TTL      = 40;
    localparam int N_NAT      = 40;
    localparam int N_DROP     = 10;
    localparam int N_BP       = 30;
    localparam int N_HDR      = 1 + N_TTL + N_NAT + 2 * N_DROP + N_BP;
    localparam int APB_OPS    = 40;
    localparam int MAX_CYCLES = N_HDR * 12 + APB_OPS * 4 + 2000;   // Margin covers stalls.

    logic                  clk;
    logic                  reset_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [APB_ADDR_W-1:0] paddr_i;
    logic [APB_DATA_W-1:0] pwdata_i;
    logic [APB_DATA_W-1:0] prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic                  hdr_valid_i;
    logic [HDR_BITS-1:0]   hdr_i;
    logic                  hdr_ready_o;
    logic                  out_valid_o;
    logic [HDR_BITS-1:0]   out_hdr_o;
    logic                  out_drop_o;
    logic                  out_ready_i;

    // Model state.
    logic                  cfg_ttl_dec;
    logic                  cfg_nat_en;
    logic [ADDR_W-1:0]     cfg_nat_addr;
    int                    model_fwd = 0;
    int                    model_drop = 0;
    logic [HDR_BITS-1:0]   send_q[$];
    logic [HDR_BITS-1:0]   exp_hdr_q[$];
    logic                  exp_drop_q[$];
    int                    checks = 0;
    int                    errors = 0;
    int                    cycles = 0;

    tb_clkgen tb_clkgen_inst (.clk_o(clk), .reset_o(reset_i));

    ipv4_rw_top ipv4_rw_top_inst (
        .clk (clk), .reset_i (reset_i),
        .psel_i (psel_i), .penable_i (penable_i), .pwrite_i (pwrite_i),
        .paddr_i (paddr_i), .pwdata_i (pwdata_i), .prdata_o (prdata_o),
        .pready_o (pready_o), .pslverr_o (pslverr_o),
        .hdr_valid_i (hdr_valid_i), .hdr_i (hdr_i), .hdr_ready_o (hdr_ready_o),
        .out_valid_o (out_valid_o), .out_hdr_o (out_hdr_o),
        .out_drop_o (out_drop_o), .out_ready_i (out_ready_i)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model.
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] t;
        t = {1'b0, a} + {1'b0, b};
        return t[15:0] + {15'd0, t[16]};
    endfunction

    // Header checksum from scratch, checksum field taken as zero.
    function automatic logic [15:0] full_csum(input logic [HDR_BITS-1:0] h);
        logic [31:0] sum;
        int i;
        sum = 32'd0;
        h[CSUM_LSB +: 16] = 16'h0000;
        for (i = 0; i < HDR_BITS / 16; i++) sum = sum + h[i*16 +: 16];
        sum = (sum & 32'hFFFF) + (sum >> 16);
        sum = (sum & 32'hFFFF) + (sum >> 16);
        return ~sum[15:0];
    endfunction

    function automatic logic [HDR_BITS-1:0] make_hdr(input logic [7:0] ttl,
                                                     input logic [31:0] src);
        logic [HDR_BITS-1:0] h;
        h = {8'h45, 8'($urandom), 16'($urandom_range(1500, 20)), 16'($urandom),
             16'($urandom), ttl, 8'($urandom), 16'h0000, src, 32'($urandom)};
        h[CSUM_LSB +: 16] = full_csum(h);
        return h;
    endfunction

    task automatic queue_header(input logic [HDR_BITS-1:0] h);
        logic                drop;
        logic [HDR_BITS-1:0] m;
        drop = cfg_ttl_dec && (h[TTL_LSB+8 +: 8] <= 8'd1);    // Would expire here.
        m = h;
        if (!drop) begin
            if (cfg_ttl_dec) m[TTL_LSB+8 +: 8] = h[TTL_LSB+8 +: 8] - 8'd1;
            if (cfg_nat_en)  m[SRC_LO_LSB +: 32] = cfg_nat_addr;
            m[CSUM_LSB +: 16] = full_csum(m);
        end
        send_q.push_back(h);
        exp_hdr_q.push_back(m);
        exp_drop_q.push_back(drop);
        if (drop) model_drop++;
        else      model_fwd++;
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks.
    ////////////////////////////////////////////////////////////
    task automatic hdr_compare(input logic [HDR_BITS-1:0] got, input logic [HDR_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail time=%0t signal=out_hdr_o got=%h exp=%h", $time, got, exp);
        end
    endtask

    task automatic flag_compare(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail time=%0t signal=%s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic prdata_compare(input string name, input logic [APB_DATA_W-1:0] got,
                                  input logic [APB_DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail time=%0t signal=prdata_o(%s) got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and stream drivers.
    ////////////////////////////////////////////////////////////
    task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                              input logic [APB_DATA_W-1:0] wdata,
                              output logic [APB_DATA_W-1:0] rdata, output logic err);
        @(negedge clk);
        psel_i    = 1'b1;                   // Setup phase.
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(negedge clk);
        penable_i = 1'b1;
        @(posedge clk);
        while (!pready_o) @(posedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic set_config(input logic ttl_dec, input logic nat_en, input logic [31:0] nat);
        logic [APB_DATA_W-1:0] ctrl;
        logic [APB_DATA_W-1:0] rd;
        logic                  err;
        ctrl = '0;
        ctrl[CTRL_TTL_DEC_BIT] = ttl_dec;
        ctrl[CTRL_NAT_EN_BIT]  = nat_en;
        apb_access(1'b1, REG_CTRL, ctrl, rd, err);
        apb_access(1'b1, REG_NAT_ADDR, nat, rd, err);
        apb_access(1'b0, REG_CTRL, '0, rd, err);
        prdata_compare("ctrl", rd, ctrl);
        apb_access(1'b0, REG_NAT_ADDR, '0, rd, err);
        prdata_compare("nat_addr", rd, nat);
        cfg_ttl_dec  = ttl_dec;
        cfg_nat_en   = nat_en;
        cfg_nat_addr = nat;
    endtask

    task automatic drive_headers();
        while (send_q.size() > 0) begin
            @(negedge clk);
            hdr_valid_i = 1'b1;
            hdr_i       = send_q.pop_front();
            while (!hdr_ready_o) @(negedge clk);
            @(negedge clk);                 // Taken on the edge just passed.
            hdr_valid_i = 1'b0;
        end
    endtask

    task automatic collect_outputs(input int n, input logic bp);
        int                  got;
        logic                held;
        logic [HDR_BITS-1:0] held_hdr;
        logic                held_drop;
        got  = 0;
        held = 1'b0;
        while (got < n) begin
            @(negedge clk);
            if (out_valid_o) begin
                if (!held) begin
                    if (exp_hdr_q.size() == 0) begin
                        errors++;
                        $display("Output header appeared with none outstanding");
                    end else begin
                        hdr_compare(out_hdr_o, exp_hdr_q.pop_front());
                        flag_compare("out_drop_o", out_drop_o, exp_drop_q.pop_front());
                    end
                    held      = 1'b1;
                    held_hdr  = out_hdr_o;
                    held_drop = out_drop_o;
                end else begin
                    // Stalled output must not move.
                    hdr_compare(out_hdr_o, held_hdr);
                    flag_compare("out_drop_o", out_drop_o, held_drop);
                end
                out_ready_i = bp ? ($urandom_range(3) == 0) : 1'b1;
                if (out_ready_i) begin
                    held = 1'b0;
                    got++;
                end
            end else begin
                if (held) begin
                    flag_compare("out_valid_o", out_valid_o, 1'b1);
                end
                held = 1'b0;
                out_ready_i = bp ? 1'($urandom_range(1)) : 1'b1;
            end
        end
    endtask

    task automatic run_batch(input string name, input logic bp);
        int err0;
        int n;
        err0 = errors;
        n    = send_q.size();
        fork
            drive_headers();
            collect_outputs(n, bp);
        join
        $display("%s: %0d headers, %0d errors", name, n, errors - err0);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests.
    ////////////////////////////////////////////////////////////
    initial begin
        logic [HDR_BITS-1:0]   h;
        logic [HDR_BITS-1:0]   keep[$];
        logic [31:0]           nat;
        logic [31:0]           src;
        logic [APB_DATA_W-1:0] rd;
        logic                  rd_err;
        int                    err0;
        int unsigned           assert_fails;

        void'($urandom(32'h897c));
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        paddr_i     = '0;
        pwdata_i    = '0;
        hdr_valid_i = 1'b0;
        hdr_i       = '0;
        out_ready_i = 1'b1;
        @(negedge reset_i);

        // RFC 1624 example, one source half 0x5555 -> 0x3285.
        set_config(1'b0, 1'b1, {16'hC0A8, 16'h3285});
        h = {8'h45, 8'h00, 16'h0054, 16'h0000, 16'h0000, 8'h40, 8'h11, 16'h0000,
             16'hC0A8, 16'h5555, 32'h0A000001};
        h[112 +: 16] = ones_add(16'h22D0, full_csum(h));   // Id word sets the sum.
        h[CSUM_LSB +: 16] = full_csum(h);
        if (h[CSUM_LSB +: 16] !== 16'hDD2F) begin
            errors++;
            $display("RFC 1624 header built with checksum %h instead of dd2f",
                     h[CSUM_LSB +: 16]);
        end
        queue_header(h);
        if (exp_hdr_q[0][CSUM_LSB +: 16] !== 16'h0000) begin
            errors++;
            $display("Model checksum for the RFC 1624 header is not 0000");
        end
        run_batch("test 1 rfc1624 vector", 1'b0);

        set_config(1'b1, 1'b0, 32'h0);
        repeat (N_TTL) queue_header(make_hdr(8'($urandom_range(255, 2)), $urandom));
        run_batch("test 2 ttl decrement", 1'b0);

        nat = $urandom;
        set_config(1'b1, 1'b1, nat);
        repeat (N_NAT) begin
            case ($urandom_range(3))
                0:       src = nat;                     // Nothing left to rewrite.
                1:       src = {nat[31:16], 16'($urandom)};
                2:       src = {16'($urandom), nat[15:0]};
                default: src = $urandom;
            endcase
            queue_header(make_hdr(8'($urandom_range(255, 2)), src));
        end
        run_batch("test 3 nat and ttl", 1'b0);

        // Same expiring headers, decrement on and then off.
        repeat (N_DROP) begin
            h = make_hdr(8'($urandom_range(1)), $urandom);
            keep.push_back(h);
            queue_header(h);
        end
        run_batch("test 4 drop, decrement on", 1'b0);
        set_config(1'b0, 1'b0, nat);
        foreach (keep[i]) queue_header(keep[i]);
        run_batch("test 4 drop, decrement off", 1'b0);

        set_config(1'b1, 1'b1, $urandom);
        repeat (N_BP) queue_header(make_hdr(8'($urandom), $urandom));
        run_batch("test 5 back-pressure", 1'b1);

        err0 = errors;
        apb_access(1'b0, REG_PKT_CNT, '0, rd, rd_err);
        prdata_compare("pkt_cnt", rd, model_fwd);
        flag_compare("pslverr_o", rd_err, 1'b0);
        apb_access(1'b0, REG_DROP_CNT, '0, rd, rd_err);
        prdata_compare("drop_cnt", rd, model_drop);
        apb_access(1'b1, REG_PKT_CNT, $urandom, rd, rd_err);
        apb_access(1'b1, REG_DROP_CNT, $urandom, rd, rd_err);
        apb_access(1'b0, REG_PKT_CNT, '0, rd, rd_err);
        prdata_compare("pkt_cnt", rd, '0);
        apb_access(1'b0, REG_DROP_CNT, '0, rd, rd_err);
        prdata_compare("drop_cnt", rd, '0);
        apb_access(1'b0, 8'h10, '0, rd, rd_err);          // Unmapped.
        flag_compare("pslverr_o", rd_err, 1'b1);
        $display("test 6 registers: %0d errors", errors - err0);

        assert_fails = ipv4_rw_top_inst.ipv4_hdr_rewrite_inst.ipv4_rw_assert_inst.fail_cnt;
        $display("checks=%0d errors=%0d assertion_failures=%0d", checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
ipv4_rw_pkg.sv
csum_if.sv
ipv4_checksum_update.sv
rewrite_cfg_apb.sv
ipv4_hdr_rewrite.sv
ipv4_rw_top.sv
ipv4_rw_assert.sv
tb_clkgen.sv
tb_top.sv
